// ==== sim.f ====
logic/fx_core_pkg.sv
logic/operand_if.sv
logic/writeback_if.sv
logic/pending_scoreboard.sv
logic/register_unit.sv
logic/fx_unit.sv
logic/fx_issue_top.sv
dv/tb_fx_issue.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fx_issue -f sim.f
	./obj_dir/Vtb_fx_issue | tee /dev/stderr | grep "^test passed$$" > /dev/null

clean:
	rm -rf obj_dir

// ==== dv/tb_fx_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fx_issue;

	typedef struct {
		bit                                      is_load;  // load/store port write
		fx_core_pkg::fx_opcode_e                 op;
		logic [fx_core_pkg::reg_addr_width-1:0]  ra;
		logic [fx_core_pkg::reg_addr_width-1:0]  rb;
		logic [fx_core_pkg::reg_addr_width-1:0]  rt;
		logic [fx_core_pkg::imm_width-1:0]       imm;
		fx_core_pkg::operand_src_e               src;
		bit                                      ra_zero;
		bit                                      stall;    // stall on first try
		logic [fx_core_pkg::data_width-1:0]      data;     // load value
		logic [fx_core_pkg::data_width-1:0]      expected; // wb data, cr0 in low bits
		string                                   name;
	} entry_t;

	logic                                    clock_i;
	logic                                    reset_i;
	logic                                    issue_valid_i;
	fx_core_pkg::fx_opcode_e                 opcode_i;
	logic [fx_core_pkg::reg_addr_width-1:0]  ra_i;
	logic [fx_core_pkg::reg_addr_width-1:0]  rb_i;
	logic [fx_core_pkg::reg_addr_width-1:0]  rt_i;
	logic [fx_core_pkg::imm_width-1:0]       imm_i;
	fx_core_pkg::operand_src_e               b_src_i;
	logic                                    ra_zero_i;
	logic                                    ldst_wb_valid_i;
	logic [fx_core_pkg::reg_addr_width-1:0]  ldst_wb_addr_i;
	logic [fx_core_pkg::data_width-1:0]      ldst_wb_data_i;
	logic                                    stall_o;
	logic                                    wb_valid_o;
	logic [fx_core_pkg::reg_addr_width-1:0]  wb_addr_o;
	logic [fx_core_pkg::data_width-1:0]      wb_data_o;
	logic [fx_core_pkg::cr_field_width-1:0]  cr0_o;

	entry_t                                  table_a [64];
	int                                      table_count;
	logic [fx_core_pkg::data_width-1:0]      model_gpr [fx_core_pkg::num_regs]; // reference gprs
	logic [fx_core_pkg::reg_addr_width-1:0]  exp_addr_q [$]; // outstanding, issue order
	logic [fx_core_pkg::data_width-1:0]      exp_data_q [$];
	string                                   exp_name_q [$];
	integer                                  seed;
	int                                      error_count;
	int                                      wait_limit = 40; // cycles per wait

	fx_issue_top fx_issue_top_i (.*);

	always #20 clock_i = ~clock_i; // 40 ns period

	function automatic void load_entry(input string name, input int rt,
		input logic [fx_core_pkg::data_width-1:0] data);
		table_a[table_count].is_load = 1'b1;
		table_a[table_count].rt      = rt[fx_core_pkg::reg_addr_width-1:0];
		table_a[table_count].data    = data;
		table_a[table_count].name    = name;
		table_count++;
	endfunction

	function automatic void issue_entry(input string name, input fx_core_pkg::fx_opcode_e op,
		input int ra, input int rb, input int rt, input logic [fx_core_pkg::imm_width-1:0] imm,
		input bit use_imm, input bit ra_zero, input bit stall);
		entry_t e;
		e.is_load = 1'b0;
		e.op      = op;
		e.ra      = ra[fx_core_pkg::reg_addr_width-1:0];
		e.rb      = rb[fx_core_pkg::reg_addr_width-1:0];
		e.rt      = rt[fx_core_pkg::reg_addr_width-1:0];
		e.imm     = imm;
		e.src     = use_imm ? fx_core_pkg::SRC_IMM : fx_core_pkg::SRC_REG;
		e.ra_zero = ra_zero;
		e.stall   = stall;
		e.name    = name;
		table_a[table_count] = e;
		table_count++;
	endfunction

	// walks the table in program order against the model gprs
	function automatic void compute_expected();
		entry_t                             e;
		logic [fx_core_pkg::data_width-1:0] a;
		logic [fx_core_pkg::data_width-1:0] b;
		for (int i = 0; i < fx_core_pkg::num_regs; i++)
			model_gpr[i] = '0; // reset state
		for (int n = 0; n < table_count; n++) begin
			e = table_a[n];
			if (e.is_load) begin
				model_gpr[e.rt] = e.data;
			end else begin
				a = (e.ra_zero && e.ra == 0) ? '0 : model_gpr[e.ra];
				b = (e.src == fx_core_pkg::SRC_IMM) ? {{48{e.imm[15]}}, e.imm} : model_gpr[e.rb];
				case (e.op)
					fx_core_pkg::OP_ADD:  e.expected = a + b;
					fx_core_pkg::OP_SUBF: e.expected = b - a;
					fx_core_pkg::OP_AND:  e.expected = a & b;
					fx_core_pkg::OP_OR:   e.expected = a | b;
					fx_core_pkg::OP_XOR:  e.expected = a ^ b;
					default: begin
						if ($signed(a) < $signed(b))
							e.expected = 64'b1000; // lt
						else if ($signed(a) > $signed(b))
							e.expected = 64'b0100; // gt
						else
							e.expected = 64'b0010; // eq
					end
				endcase
				if (e.op != fx_core_pkg::OP_CMP)
					model_gpr[e.rt] = e.expected;
				table_a[n] = e;
			end
		end
	endfunction

	task automatic timeout_abort(input string what);
		$display("timeout while waiting for %s", what);
		$display("errors: %0d", error_count);
		$display("test failed");
		$finish;
	endtask

	// until every expected writeback has been seen
	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_data_q.size() != 0) begin
			@(negedge clock_i);
			cycles++;
			if (cycles > wait_limit)
				timeout_abort("outstanding writebacks");
		end
	endtask

	// returns on the accepting rising edge
	task automatic wait_accept();
		int cycles;
		cycles = 0;
		while (stall_o) begin
			@(negedge clock_i);
			#1;
			cycles++;
			if (cycles > wait_limit)
				timeout_abort("stall to clear");
		end
		@(posedge clock_i);
	endtask

	task automatic apply_entry(input entry_t e);
		if (e.is_load) begin
			wait_drain();
			ldst_wb_valid_i = 1'b1; // one cycle, cleared by the next entry
			ldst_wb_addr_i  = e.rt;
			ldst_wb_data_i  = e.data;
		end else begin
			if (e.op == fx_core_pkg::OP_CMP)
				wait_drain(); // cr0 checked on a quiet pipe
			opcode_i      = e.op;
			ra_i          = e.ra;
			rb_i          = e.rb;
			rt_i          = e.rt;
			imm_i         = e.imm;
			b_src_i       = e.src;
			ra_zero_i     = e.ra_zero;
			issue_valid_i = 1'b1;
			if (e.op != fx_core_pkg::OP_CMP) begin
				exp_addr_q.push_back(e.rt);
				exp_data_q.push_back(e.expected);
				exp_name_q.push_back(e.name);
			end
			#1;
			assert (stall_o == e.stall) else begin
				$display("Fail %s: expected stall %0b, got %0b", e.name, e.stall, stall_o);
				error_count++;
			end
			wait_accept();
			if (e.op == fx_core_pkg::OP_CMP) begin
				@(negedge clock_i);
				issue_valid_i = 1'b0;
				// cr0 lands at the end of the third cycle after acceptance
				repeat (fx_core_pkg::fx_latency + 1) @(posedge clock_i);
				@(negedge clock_i);
				assert (cr0_o == e.expected[fx_core_pkg::cr_field_width-1:0]) else begin
					$display("Fail %s: expected cr0 %b, got %b", e.name,
						e.expected[fx_core_pkg::cr_field_width-1:0], cr0_o);
					error_count++;
				end
			end
		end
	endtask

	////////////////////////////////////////
	// writeback monitor
	////////////////////////////////////////
	always @(posedge clock_i) begin
		if (!reset_i && wb_valid_o) begin
			assert (exp_data_q.size() != 0) else begin
				$display("writeback to r%0d arrived with nothing outstanding", wb_addr_o);
				error_count++;
			end
			if (exp_data_q.size() != 0) begin
				assert (wb_addr_o == exp_addr_q[0] && wb_data_o == exp_data_q[0]) else begin
					$display("Fail %s: expected r%0d = %h, got r%0d = %h", exp_name_q[0],
						exp_addr_q[0], exp_data_q[0], wb_addr_o, wb_data_o);
					error_count++;
				end
				void'(exp_addr_q.pop_front());
				void'(exp_data_q.pop_front());
				void'(exp_name_q.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////
	task automatic build_table();
		table_count = 0;
		// every gpr reads zero out of reset, all back to back
		for (int i = 0; i < fx_core_pkg::num_regs; i++)
			issue_entry($sformatf("reset_read_r%0d", i), fx_core_pkg::OP_OR, i, i, i, 16'h0,
				0, 0, 0);
		for (int i = 0; i <= 8; i++)
			load_entry($sformatf("preload_r%0d", i), i, {$random(seed), $random(seed)});
		// name, op, ra, rb, rt, imm, use_imm, ra_zero, stall
		issue_entry("add", fx_core_pkg::OP_ADD, 1, 2, 10, 16'h0000, 0, 0, 0);
		issue_entry("subf", fx_core_pkg::OP_SUBF, 1, 2, 11, 16'h0000, 0, 0, 0);
		issue_entry("and", fx_core_pkg::OP_AND, 3, 4, 12, 16'h0000, 0, 0, 0);
		issue_entry("or", fx_core_pkg::OP_OR, 3, 5, 13, 16'h0000, 0, 0, 0);
		issue_entry("xor", fx_core_pkg::OP_XOR, 4, 5, 14, 16'h0000, 0, 0, 0);
		issue_entry("addi_pos", fx_core_pkg::OP_ADD, 6, 0, 15, 16'h7fff, 1, 0, 0);
		issue_entry("addi_neg", fx_core_pkg::OP_ADD, 6, 0, 16, 16'h8000, 1, 0, 0);
		issue_entry("andi_neg", fx_core_pkg::OP_AND, 7, 0, 17, 16'hfff0, 1, 0, 0);
		issue_entry("li_neg", fx_core_pkg::OP_ADD, 0, 0, 18, 16'hff9c, 1, 1, 0); // r0 is nonzero
		issue_entry("add_ra_zero", fx_core_pkg::OP_ADD, 0, 8, 19, 16'h0000, 0, 1, 0);
		issue_entry("add_r0", fx_core_pkg::OP_ADD, 0, 8, 20, 16'h0000, 0, 0, 0);
		// raw chain through r21 and r22
		issue_entry("dep_head", fx_core_pkg::OP_ADD, 1, 2, 21, 16'h0000, 0, 0, 0);
		issue_entry("dep_raw", fx_core_pkg::OP_SUBF, 3, 21, 22, 16'h0000, 0, 0, 1);
		issue_entry("dep_chain", fx_core_pkg::OP_XOR, 22, 5, 23, 16'h0000, 0, 0, 1);
		load_entry("cmp_neg", 24, 64'hffff_ffff_ffff_fffb); // -5
		load_entry("cmp_pos", 25, 64'd7);
		issue_entry("cmp_lt", fx_core_pkg::OP_CMP, 24, 25, 0, 16'h0000, 0, 0, 0);
		issue_entry("cmp_gt", fx_core_pkg::OP_CMP, 25, 24, 0, 16'h0000, 0, 0, 0);
		issue_entry("cmp_eq_imm", fx_core_pkg::OP_CMP, 24, 0, 0, 16'hfffb, 1, 0, 0);
		issue_entry("cmp_ra_zero", fx_core_pkg::OP_CMP, 0, 0, 0, 16'h0001, 1, 1, 0);
	endtask

	initial begin
		seed            = 32'ha13d_d797;
		error_count     = 0;
		clock_i         = 1'b0;
		reset_i         = 1'b1;
		issue_valid_i   = 1'b0;
		opcode_i        = fx_core_pkg::OP_ADD;
		ra_i            = '0;
		rb_i            = '0;
		rt_i            = '0;
		imm_i           = '0;
		b_src_i         = fx_core_pkg::SRC_REG;
		ra_zero_i       = 1'b0;
		ldst_wb_valid_i = 1'b0;
		ldst_wb_addr_i  = '0;
		ldst_wb_data_i  = '0;
		build_table();
		compute_expected();
		repeat (4) @(negedge clock_i);
		reset_i = 1'b0;
		#1;
		assert (stall_o == 1'b0 && wb_valid_o == 1'b0 && cr0_o == '0) else begin
			$display("outputs not idle after reset");
			error_count++;
		end
		for (int n = 0; n < table_count; n++) begin
			@(negedge clock_i);
			issue_valid_i   = 1'b0;
			ldst_wb_valid_i = 1'b0;
			apply_entry(table_a[n]);
		end
		@(negedge clock_i);
		issue_valid_i   = 1'b0;
		ldst_wb_valid_i = 1'b0;
		wait_drain();
		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/fx_issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fx_issue_top (
	input  logic                                    clock_i,
	input  logic                                    reset_i,
	input  logic                                    issue_valid_i,
	input  fx_core_pkg::fx_opcode_e                 opcode_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  ra_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rb_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rt_i,
	input  logic [fx_core_pkg::imm_width-1:0]       imm_i,
	input  fx_core_pkg::operand_src_e               b_src_i,
	input  logic                                    ra_zero_i,
	input  logic                                    ldst_wb_valid_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  ldst_wb_addr_i,
	input  logic [fx_core_pkg::data_width-1:0]      ldst_wb_data_i,
	output logic                                    stall_o,
	output logic                                    wb_valid_o,
	output logic [fx_core_pkg::reg_addr_width-1:0]  wb_addr_o,
	output logic [fx_core_pkg::data_width-1:0]      wb_data_o,
	output logic [fx_core_pkg::cr_field_width-1:0]  cr0_o
);

	operand_if   op_if (); // register unit to fx unit
	writeback_if wb_if (); // fx unit back to register unit

	register_unit register_unit_i (
		.clock_i         (clock_i),
		.reset_i         (reset_i),
		.issue_valid_i   (issue_valid_i),
		.opcode_i        (opcode_i),
		.ra_i            (ra_i),
		.rb_i            (rb_i),
		.rt_i            (rt_i),
		.imm_i           (imm_i),
		.b_src_i         (b_src_i),
		.ra_zero_i       (ra_zero_i),
		.ldst_wb_valid_i (ldst_wb_valid_i),
		.ldst_wb_addr_i  (ldst_wb_addr_i),
		.ldst_wb_data_i  (ldst_wb_data_i),
		.stall_o         (stall_o),
		.cr0_o           (cr0_o),
		.op              (op_if.issuer),
		.wb              (wb_if.consumer)
	);

	fx_unit fx_unit_i (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.op      (op_if.executor),
		.wb      (wb_if.producer)
	);

	// gpr writeback visible outside
	assign wb_valid_o = wb_if.valid;
	assign wb_addr_o  = wb_if.addr;
	assign wb_data_o  = wb_if.data;

endmodule

`default_nettype wire

// ==== logic/fx_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fx_unit (
	input  logic         clock_i,
	input  logic         reset_i,
	operand_if.executor  op,
	writeback_if.producer wb
);

	// stage 1 state
	logic                                    s1_valid_q;
	logic                                    s1_write_q;  // gpr target
	logic                                    s1_cmp_q;    // cr0 target
	logic [fx_core_pkg::reg_addr_width-1:0]  s1_addr_q;
	logic [fx_core_pkg::data_width-1:0]      s1_result_q;
	logic [fx_core_pkg::cr_field_width-1:0]  s1_flags_q;

	logic [fx_core_pkg::data_width-1:0]      result;
	logic [fx_core_pkg::cr_field_width-1:0]  flags;

	////////////////////////////////////////
	// stage 1 alu
	////////////////////////////////////////
	always_comb begin
		case (op.opcode)
			fx_core_pkg::OP_ADD:  result = op.operand_a + op.operand_b;
			fx_core_pkg::OP_SUBF: result = op.operand_b - op.operand_a; // subtract from
			fx_core_pkg::OP_AND:  result = op.operand_a & op.operand_b;
			fx_core_pkg::OP_OR:   result = op.operand_a | op.operand_b;
			fx_core_pkg::OP_XOR:  result = op.operand_a ^ op.operand_b;
			default:              result = '0;
		endcase
	end

	// lt gt eq, so stays 0 with no xer
	assign flags = {$signed(op.operand_a) < $signed(op.operand_b),
		$signed(op.operand_a) > $signed(op.operand_b),
		op.operand_a == op.operand_b,
		1'b0};

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			s1_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= op.valid;
		end
	end

	always_ff @(posedge clock_i) begin
		if (op.valid) begin
			s1_write_q  <= op.target_enable;
			s1_cmp_q    <= (op.opcode == fx_core_pkg::OP_CMP);
			s1_addr_q   <= op.target_addr;
			s1_result_q <= result;
			s1_flags_q  <= flags;
		end
	end

	////////////////////////////////////////
	// stage 2 writeback register
	////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			wb.valid    <= 1'b0;
			wb.cr_valid <= 1'b0;
		end else begin
			wb.valid    <= s1_valid_q && s1_write_q;
			wb.cr_valid <= s1_valid_q && s1_cmp_q; // compare goes to cr0 only
		end
	end

	always_ff @(posedge clock_i) begin
		wb.addr     <= s1_addr_q;
		wb.data     <= s1_result_q;
		wb.cr_field <= s1_flags_q;
	end

	a_wb_exclusive: assert property (@(posedge clock_i) disable iff (reset_i)
		!(wb.valid && wb.cr_valid))
		else $error("gpr and cr writeback in the same cycle");

	// fixed pipeline depth, every issued op comes out
	a_fixed_latency: assert property (@(posedge clock_i) disable iff (reset_i)
		op.valid |-> ##(fx_core_pkg::fx_latency) (wb.valid || wb.cr_valid))
		else $error("fx result missing %0d cycles after issue", fx_core_pkg::fx_latency);

endmodule

`default_nettype wire

// ==== logic/register_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_unit (
	input  logic                                    clock_i,
	input  logic                                    reset_i,
	// issue side
	input  logic                                    issue_valid_i,
	input  fx_core_pkg::fx_opcode_e                 opcode_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  ra_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rb_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rt_i,
	input  logic [fx_core_pkg::imm_width-1:0]       imm_i,
	input  fx_core_pkg::operand_src_e               b_src_i,
	input  logic                                    ra_zero_i,  // ra value or zero form
	// load/store writeback
	input  logic                                    ldst_wb_valid_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  ldst_wb_addr_i,
	input  logic [fx_core_pkg::data_width-1:0]      ldst_wb_data_i,
	output logic                                    stall_o,
	output logic [fx_core_pkg::cr_field_width-1:0]  cr0_o,
	operand_if.issuer                               op,
	writeback_if.consumer                           wb
);

	logic [fx_core_pkg::data_width-1:0] gpr_q [fx_core_pkg::num_regs]; // general registers

	logic                               ra_is_zero; // r0 substituted with 0
	logic                               read_rb;
	logic                               hazard;
	logic                               accept;
	logic [fx_core_pkg::data_width-1:0] a_value;
	logic [fx_core_pkg::data_width-1:0] b_value;
	logic [fx_core_pkg::data_width-1:0] imm_ext;

	////////////////////////////////////////
	// operand select and stall
	////////////////////////////////////////
	assign ra_is_zero = ra_zero_i && (ra_i == '0);
	assign read_rb    = (b_src_i == fx_core_pkg::SRC_REG);
	assign imm_ext    = {
		{(fx_core_pkg::data_width - fx_core_pkg::imm_width){imm_i[fx_core_pkg::imm_width-1]}},
		imm_i};

	assign a_value = ra_is_zero ? '0 : gpr_q[ra_i];
	assign b_value = read_rb ? gpr_q[rb_i] : imm_ext;

	assign stall_o = issue_valid_i & hazard; // combinational, no forwarding
	assign accept  = issue_valid_i & ~hazard;

	pending_scoreboard pending_scoreboard_i (
		.clock_i        (clock_i),
		.reset_i        (reset_i),
		.check_ra_i     (~ra_is_zero),
		.check_rb_i     (read_rb),
		.ra_i           (ra_i),
		.rb_i           (rb_i),
		.rt_i           (rt_i),
		.set_i          (accept && (opcode_i != fx_core_pkg::OP_CMP)), // cmp has no gpr target
		.set_addr_i     (rt_i),
		.clear_a_i      (wb.valid),
		.clear_a_addr_i (wb.addr),
		.clear_b_i      (ldst_wb_valid_i),
		.clear_b_addr_i (ldst_wb_addr_i),
		.hazard_o       (hazard)
	);

	////////////////////////////////////////
	// issue register
	////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (reset_i)
			op.valid <= 1'b0;
		else
			op.valid <= accept; // high the cycle after acceptance
	end

	always_ff @(posedge clock_i) begin
		if (accept) begin
			op.opcode        <= opcode_i;
			op.operand_a     <= a_value;
			op.operand_b     <= b_value;
			op.target_addr   <= rt_i;
			op.target_enable <= (opcode_i != fx_core_pkg::OP_CMP);
		end
	end

	////////////////////////////////////////
	// writeback into gpr and cr
	////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < fx_core_pkg::num_regs; i++)
				gpr_q[i] <= '0;
			cr0_o <= '0;
		end else begin
			if (ldst_wb_valid_i)
				gpr_q[ldst_wb_addr_i] <= ldst_wb_data_i;
			if (wb.valid)
				gpr_q[wb.addr] <= wb.data; // later write, fx port wins a collision
			if (wb.cr_valid)
				cr0_o <= wb.cr_field;
		end
	end

	// a stalled instruction waits in place until accepted
	a_stall_holds_issue: assert property (@(posedge clock_i) disable iff (reset_i)
		stall_o |=> issue_valid_i
			&& $stable({opcode_i, ra_i, rb_i, rt_i, imm_i, b_src_i, ra_zero_i}))
		else $error("issue inputs changed while stalled");

	// both writeback ports on one register, fx result kept
	a_wb_port_collision: assert property (@(posedge clock_i) disable iff (reset_i)
		!(wb.valid && ldst_wb_valid_i && (wb.addr == ldst_wb_addr_i)))
		else $warning("fx and load/store writeback both hit r%0d", wb.addr);

endmodule

`default_nettype wire

// ==== logic/pending_scoreboard.sv ====
`timescale 1ns/1ns
`default_nettype none

module pending_scoreboard (
	input  logic                                    clock_i,
	input  logic                                    reset_i,
	input  logic                                    check_ra_i,     // ra actually read
	input  logic                                    check_rb_i,     // rb actually read
	input  logic [fx_core_pkg::reg_addr_width-1:0]  ra_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rb_i,
	input  logic [fx_core_pkg::reg_addr_width-1:0]  rt_i,
	input  logic                                    set_i,          // accepted, rt now in flight
	input  logic [fx_core_pkg::reg_addr_width-1:0]  set_addr_i,
	input  logic                                    clear_a_i,      // fx unit writeback
	input  logic [fx_core_pkg::reg_addr_width-1:0]  clear_a_addr_i,
	input  logic                                    clear_b_i,      // load/store writeback
	input  logic [fx_core_pkg::reg_addr_width-1:0]  clear_b_addr_i,
	output logic                                    hazard_o
);

	logic [fx_core_pkg::num_regs-1:0] pending_q; // one bit per gpr

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			pending_q <= '0; // nothing in flight
		end else begin
			if (clear_b_i)
				pending_q[clear_b_addr_i] <= 1'b0;
			if (clear_a_i)
				pending_q[clear_a_addr_i] <= 1'b0;
			if (set_i)
				pending_q[set_addr_i] <= 1'b1; // last assignment, set beats clear
		end
	end

	// raw on sources, waw on target
	assign hazard_o = (check_ra_i & pending_q[ra_i])
		| (check_rb_i & pending_q[rb_i])
		| pending_q[rt_i];

	// fx results only ever come back for registers marked at issue
	a_fx_clear_was_pending: assert property (@(posedge clock_i) disable iff (reset_i)
		clear_a_i |-> pending_q[clear_a_addr_i])
		else $error("fx writeback to r%0d which was not pending", clear_a_addr_i);

endmodule

`default_nettype wire

// ==== logic/writeback_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// result path back into the register unit
interface writeback_if;

	logic                                    valid;    // gpr write plus pending clear
	logic [fx_core_pkg::reg_addr_width-1:0]  addr;
	logic [fx_core_pkg::data_width-1:0]      data;
	logic                                    cr_valid; // cr field 0 write
	logic [fx_core_pkg::cr_field_width-1:0]  cr_field;

	modport producer (output valid, addr, data, cr_valid, cr_field);

	modport consumer (input valid, addr, data, cr_valid, cr_field);

endinterface

`default_nettype wire

// ==== logic/operand_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one issued instruction, register unit to fx unit
interface operand_if;

	logic                                    valid;         // one cycle strobe
	fx_core_pkg::fx_opcode_e                 opcode;
	logic [fx_core_pkg::data_width-1:0]      operand_a;     // ra value or zero
	logic [fx_core_pkg::data_width-1:0]      operand_b;     // rb or imm
	logic [fx_core_pkg::reg_addr_width-1:0]  target_addr;   // rt
	logic                                    target_enable; // low for compares

	// no ready, the fx unit takes one item every cycle
	modport issuer (
		output valid, opcode, operand_a, operand_b, target_addr, target_enable
	);

	modport executor (
		input valid, opcode, operand_a, operand_b, target_addr, target_enable
	);

endinterface

`default_nettype wire

// ==== logic/fx_core_pkg.sv ====
`default_nettype none

package fx_core_pkg;

	////////////////////////////////////////
	// datapath sizes
	////////////////////////////////////////
	localparam int data_width     = 64; // gpr and result width
	localparam int reg_addr_width = 5;
	localparam int num_regs       = 32;
	localparam int imm_width      = 16; // d-form immediate
	localparam int cr_field_width = 4;  // lt gt eq so
	localparam int fx_latency     = 2;  // operand valid to writeback valid

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	// fixed point operations
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0, // a + b
		OP_SUBF = 3'd1, // b - a, power style subtract from
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_CMP  = 3'd5  // signed compare into cr0, no gpr write
	} fx_opcode_e;

	// where operand b comes from
	typedef enum logic {
		SRC_REG = 1'b0, // gpr rb
		SRC_IMM = 1'b1  // sign extended immediate
	} operand_src_e;

endpackage

`default_nettype wire
